//--- src/ctrlConsts_consts.svh
`ifndef CTRL_CONSTS_SVH
`define CTRL_CONSTS_SVH

////////////////////
// word and register sizes
////////////////////
`define XLEN        32  // instruction width
`define REG_ADDR_W  5   // x0..x31

////////////////////
// rv32i field positions
////////////////////
`define OPC_LSB     2   // opcode[1:0] is always 11, skipped
`define OPC_W       5
`define FUNCT3_LSB  12
`define FUNCT3_W    3
`define RS1_LSB     15
`define RS2_LSB     20
`define ALT_BIT     30  // funct7[5], picks sub / sra

// addi x0, x0, 0
// stage registers load this at reset so nothing writes or redirects
`define INST_NOP    32'h0000_0013

`endif

//--- src/ctrlPkg.sv
`include "ctrlConsts_consts.svh"

package ctrlPkg;

    // opcode[6:2] classes
    typedef enum logic [`OPC_W-1:0] {
        opLoad   = 5'b00000,
        opImm    = 5'b00100,
        opAuipc  = 5'b00101,
        opStore  = 5'b01000,
        opR      = 5'b01100,
        opLui    = 5'b01101,
        opBranch = 5'b11000,
        opJalr   = 5'b11001,
        opJal    = 5'b11011,
        opOther  = 5'b11111  // anything not decoded here
    } opClassE;

    typedef enum logic [2:0] {
        immI = 3'd0, immIShift = 3'd1, immS = 3'd2, immB = 3'd3, immU = 3'd4, immJ = 3'd5
    } immSelE;

    // alu encodings as seen by the datapath, 10 unused
    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluAnd  = 4'd2,
        aluOr   = 4'd3,
        aluXor  = 4'd4,
        aluSll  = 4'd5,
        aluSrl  = 4'd6,
        aluSra  = 4'd7,
        aluSltu = 4'd8,
        aluSlt  = 4'd9,
        aluPassB = 4'd11  // lui, imm straight through
    } aluOpE;

    typedef enum logic [1:0] {wbMem = 2'd0, wbAlu = 2'd1, wbPc4 = 2'd3} wbSelE;

    typedef enum logic [1:0] {fwdNone = 2'd0, fwdWb = 2'd1, fwdMem = 2'd2} fwdSelE;

    function automatic opClassE classOf(input logic [`OPC_W-1:0] opc);
        opClassE cls;
        case (opc)
            5'b00000: cls = opLoad;
            5'b00100: cls = opImm;
            5'b00101: cls = opAuipc;
            5'b01000: cls = opStore;
            5'b01100: cls = opR;
            5'b01101: cls = opLui;
            5'b11000: cls = opBranch;
            5'b11001: cls = opJalr;
            5'b11011: cls = opJal;
            default:  cls = opOther;  // csr, fence, illegal
        endcase
        return cls;
    endfunction

endpackage

//--- src/ctrlIf.sv
`timescale 1ns/1ps
`include "ctrlConsts_consts.svh"

////////////////////
// pipeline -> ex stage consumers
////////////////////
interface exStageIf;
    logic [`XLEN-1:0] instEx;  // instruction sitting in ex
    logic regWEnMem;           // mem stage will write rd
    logic regWEnWb;            // wb stage will write rd

    modport source (output instEx, regWEnMem, regWEnWb);
    modport sink   (input  instEx, regWEnMem, regWEnWb);
endinterface

////////////////////
// pipeline -> branch resolver
////////////////////
interface memStageIf;
    ctrlPkg::opClassE memClass;
    logic [`FUNCT3_W-1:0] funct3;  // branch condition
    logic brEqMem;                 // compare flags captured while in ex
    logic brLtMem;

    modport source (output memClass, funct3, brEqMem, brLtMem);
    modport sink   (input  memClass, funct3, brEqMem, brLtMem);
endinterface

//--- src/idDecoder.sv
`timescale 1ns/1ps
`include "ctrlConsts_consts.svh"

module idDecoder (
    input  logic [`XLEN-1:0] instruct,
    output logic jumpEarly,            // jal lets fetch redirect right away
    output logic branchEarly,          // branch goes to the predictor
    output ctrlPkg::immSelE immSel,
    output logic idMemRead,            // single bit for load-use hazard logic
    output logic regWEnId,
    output ctrlPkg::wbSelE wbSelId
);

    ctrlPkg::opClassE opClass;
    logic [`FUNCT3_W-1:0] funct3;

    assign opClass = ctrlPkg::classOf(instruct[`OPC_LSB +: `OPC_W]);
    assign funct3  = instruct[`FUNCT3_LSB +: `FUNCT3_W];

    always_comb begin
        immSel   = ctrlPkg::immI;
        regWEnId = 1'b0;
        wbSelId  = ctrlPkg::wbPc4;  // jal, jalr and unknown land here
        case (opClass)
            ctrlPkg::opR: begin
                regWEnId = 1'b1;
                wbSelId  = ctrlPkg::wbAlu;
            end
            ctrlPkg::opImm: begin
                // slli / srli / srai carry a shamt instead of a full imm
                if (funct3 == 3'b001 || funct3 == 3'b101)
                    immSel = ctrlPkg::immIShift;
                regWEnId = 1'b1;
                wbSelId  = ctrlPkg::wbAlu;
            end
            ctrlPkg::opLoad: begin
                regWEnId = 1'b1;
                wbSelId  = ctrlPkg::wbMem;
            end
            ctrlPkg::opStore: begin
                immSel  = ctrlPkg::immS;
                wbSelId = ctrlPkg::wbMem;  // no write but still a memory op
            end
            ctrlPkg::opBranch: begin
                immSel  = ctrlPkg::immB;
                wbSelId = ctrlPkg::wbMem;
            end
            ctrlPkg::opJal: begin
                immSel   = ctrlPkg::immJ;
                regWEnId = 1'b1;
            end
            ctrlPkg::opJalr: regWEnId = 1'b1;  // I format with rd = pc+4
            ctrlPkg::opAuipc, ctrlPkg::opLui: begin
                immSel   = ctrlPkg::immU;
                regWEnId = 1'b1;
                wbSelId  = ctrlPkg::wbAlu;
            end
            default: ;
        endcase
    end

    // store and branch raise this too
    assign idMemRead   = (wbSelId == ctrlPkg::wbMem);
    assign jumpEarly   = (opClass == ctrlPkg::opJal);
    assign branchEarly = (opClass == ctrlPkg::opBranch);

endmodule

//--- src/ctrlPipeline.sv
`timescale 1ns/1ps
`include "ctrlConsts_consts.svh"

module ctrlPipeline (
    input  logic clk,
    input  logic rst,
    input  logic [`XLEN-1:0] instruct,
    input  logic regWEnId,
    input  ctrlPkg::wbSelE wbSelId,
    input  logic brEq,                    // valid while the instruction is in ex
    input  logic brLt,
    exStageIf.source exBus,
    memStageIf.source memBus,
    output logic dmemWrite,
    output logic [`FUNCT3_W-1:0] memFunct3,
    output logic regWEn,
    output ctrlPkg::wbSelE regWbSel
);

    logic [`XLEN-1:0] instEx, instMem;
    logic regWEnEx, regWEnMem, regWEnWb;
    ctrlPkg::wbSelE wbSelEx, wbSelMem, wbSelWb;
    logic brEqMem, brLtMem;
    ctrlPkg::opClassE memClass;

    ////////////////////
    // stage registers
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            instEx    <= `INST_NOP;
            instMem   <= `INST_NOP;
            regWEnEx  <= 1'b0;
            regWEnMem <= 1'b0;
            regWEnWb  <= 1'b0;
            wbSelEx   <= ctrlPkg::wbMem;
            wbSelMem  <= ctrlPkg::wbMem;
            wbSelWb   <= ctrlPkg::wbMem;
        end else begin
            instEx    <= instruct;   // id -> ex
            instMem   <= instEx;     // ex -> mem
            regWEnEx  <= regWEnId;
            regWEnMem <= regWEnEx;
            regWEnWb  <= regWEnMem;  // wb only needs write control
            wbSelEx   <= wbSelId;
            wbSelMem  <= wbSelEx;
            wbSelWb   <= wbSelMem;
        end
    end

    // compare flags ride along with the ex -> mem step
    always_ff @(posedge clk) begin
        brEqMem <= brEq;
        brLtMem <= brLt;
    end

    assign memClass = ctrlPkg::classOf(instMem[`OPC_LSB +: `OPC_W]);

    assign exBus.instEx    = instEx;
    assign exBus.regWEnMem = regWEnMem;
    assign exBus.regWEnWb  = regWEnWb;

    assign memBus.memClass = memClass;
    assign memBus.funct3   = instMem[`FUNCT3_LSB +: `FUNCT3_W];
    assign memBus.brEqMem  = brEqMem;
    assign memBus.brLtMem  = brLtMem;

    assign dmemWrite = (memClass == ctrlPkg::opStore);
    assign memFunct3 = instMem[`FUNCT3_LSB +: `FUNCT3_W];  // byte / half / word size
    assign regWEn    = regWEnWb;
    assign regWbSel  = wbSelWb;

endmodule

//--- src/exControl.sv
`timescale 1ns/1ps
`include "ctrlConsts_consts.svh"

module exControl (
    exStageIf.sink exBus,
    output logic branchSigned,       // set means unsigned compare, see below
    output logic aluASel,            // 0 rs1, 1 pc
    output logic aluBSel,            // 0 rs2, 1 imm
    output ctrlPkg::aluOpE aluSel
);

    ctrlPkg::opClassE opClass;
    logic [`FUNCT3_W-1:0] funct3;
    logic altBit;

    assign opClass = ctrlPkg::classOf(exBus.instEx[`OPC_LSB +: `OPC_W]);
    assign funct3  = exBus.instEx[`FUNCT3_LSB +: `FUNCT3_W];
    assign altBit  = exBus.instEx[`ALT_BIT];

    ////////////////////
    // alu operation
    ////////////////////
    always_comb begin
        aluSel = ctrlPkg::aluAdd;  // address / pc math for everything else
        case (opClass)
            ctrlPkg::opR, ctrlPkg::opImm: begin
                case (funct3)
                    3'b000: begin
                        // addi has no sub, bit 30 is imm there
                        if (opClass == ctrlPkg::opR && altBit)
                            aluSel = ctrlPkg::aluSub;
                        else
                            aluSel = ctrlPkg::aluAdd;
                    end
                    3'b001: aluSel = ctrlPkg::aluSll;
                    3'b010: aluSel = ctrlPkg::aluSlt;
                    3'b011: aluSel = ctrlPkg::aluSltu;
                    3'b100: aluSel = ctrlPkg::aluXor;
                    3'b101: aluSel = altBit ? ctrlPkg::aluSra : ctrlPkg::aluSrl;
                    3'b110: aluSel = ctrlPkg::aluOr;
                    3'b111: aluSel = ctrlPkg::aluAnd;
                    default: ;
                endcase
            end
            ctrlPkg::opLui: aluSel = ctrlPkg::aluPassB;  // rd = imm
            default: ;
        endcase
    end

    ////////////////////
    // operand sources
    ////////////////////
    assign aluBSel = (opClass != ctrlPkg::opR);
    assign aluASel = (opClass == ctrlPkg::opBranch) ||
                     (opClass == ctrlPkg::opJal) ||
                     (opClass == ctrlPkg::opAuipc);  // target = pc + imm

    // bltu / bgeu are funct3 11x
    // lui keeps the bit high like the datapath expects, harmless there
    assign branchSigned = (opClass == ctrlPkg::opBranch && funct3[2:1] == 2'b11) ||
                          (opClass == ctrlPkg::opLui);

endmodule

//--- src/forwardUnit.sv
`timescale 1ns/1ps
`include "ctrlConsts_consts.svh"

module forwardUnit (
    input  logic [`REG_ADDR_W-1:0] memRd,
    input  logic [`REG_ADDR_W-1:0] wbRd,
    exStageIf.sink exBus,
    output ctrlPkg::fwdSelE forwardA,
    output ctrlPkg::fwdSelE forwardB,
    output ctrlPkg::fwdSelE forwardDmem,     // store data path
    output ctrlPkg::fwdSelE forwardBranchA,  // branch comparator inputs
    output ctrlPkg::fwdSelE forwardBranchB
);

    ctrlPkg::opClassE opClass;
    logic useRs1, useRs2;
    logic [`REG_ADDR_W-1:0] rs1, rs2;      // masked, x0 when not read
    ctrlPkg::fwdSelE selA, selB;

    // mem is younger than wb, so it wins
    function automatic ctrlPkg::fwdSelE pickSrc(input logic [`REG_ADDR_W-1:0] rs,
                                                input logic [`REG_ADDR_W-1:0] mRd,
                                                input logic mWEn,
                                                input logic [`REG_ADDR_W-1:0] wRd,
                                                input logic wWEn);
        ctrlPkg::fwdSelE sel;
        sel = ctrlPkg::fwdNone;
        if (mWEn && mRd != '0 && mRd == rs)
            sel = ctrlPkg::fwdMem;
        else if (wWEn && wRd != '0 && wRd == rs)
            sel = ctrlPkg::fwdWb;
        return sel;
    endfunction

    assign opClass = ctrlPkg::classOf(exBus.instEx[`OPC_LSB +: `OPC_W]);

    assign useRs2 = (opClass == ctrlPkg::opR) || (opClass == ctrlPkg::opStore) ||
                    (opClass == ctrlPkg::opBranch);
    assign useRs1 = useRs2 || (opClass == ctrlPkg::opImm) || (opClass == ctrlPkg::opLoad) ||
                    (opClass == ctrlPkg::opJalr);

    assign rs1 = useRs1 ? exBus.instEx[`RS1_LSB +: `REG_ADDR_W] : '0;
    assign rs2 = useRs2 ? exBus.instEx[`RS2_LSB +: `REG_ADDR_W] : '0;

    assign selA = pickSrc(rs1, memRd, exBus.regWEnMem, wbRd, exBus.regWEnWb);
    assign selB = pickSrc(rs2, memRd, exBus.regWEnMem, wbRd, exBus.regWEnWb);

    always_comb begin
        forwardA       = ctrlPkg::fwdNone;
        forwardB       = ctrlPkg::fwdNone;
        forwardDmem    = ctrlPkg::fwdNone;
        forwardBranchA = ctrlPkg::fwdNone;
        forwardBranchB = ctrlPkg::fwdNone;
        case (opClass)
            ctrlPkg::opBranch: begin  // comparator only, alu does pc + imm
                forwardBranchA = selA;
                forwardBranchB = selB;
            end
            ctrlPkg::opStore: begin   // rs2 is data, alu b is imm
                forwardA    = selA;
                forwardDmem = selB;
            end
            default: begin
                forwardA = selA;
                forwardB = selB;
            end
        endcase
    end

endmodule

//--- src/branchResolver.sv
`timescale 1ns/1ps

module branchResolver (
    input  logic predictedTaken,  // what fetch assumed for the mem instruction
    memStageIf.sink memBus,
    output logic pcSel,           // redirect fetch
    output logic branchResolved,  // predictor update strobe
    output logic actualTaken,
    output logic mispredict       // predicted taken, fell through
);

    logic taken;

    // condition from registered compare flags
    always_comb begin
        case (memBus.funct3)
            3'b000:         taken = memBus.brEqMem;   // beq
            3'b001:         taken = !memBus.brEqMem;  // bne
            3'b100, 3'b110: taken = memBus.brLtMem;   // blt, bltu
            3'b101, 3'b111: taken = !memBus.brLtMem;  // bge, bgeu
            default:        taken = 1'b0;
        endcase
    end

    always_comb begin
        pcSel          = 1'b0;
        branchResolved = 1'b0;
        actualTaken    = 1'b0;
        mispredict     = 1'b0;
        case (memBus.memClass)
            // jumps always go, redirect unless fetch already did
            ctrlPkg::opJal, ctrlPkg::opJalr: pcSel = !predictedTaken;
            ctrlPkg::opBranch: begin
                branchResolved = 1'b1;
                actualTaken    = taken;
                pcSel          = taken ^ predictedTaken;  // either direction wrong
                mispredict     = predictedTaken && !taken;
            end
            default: ;
        endcase
    end

endmodule

//--- src/ctrlTop.sv
`timescale 1ns/1ps
`include "ctrlConsts_consts.svh"

module ctrlTop (
    input  logic clk,
    input  logic rst,
    input  logic [`XLEN-1:0] instruct,        // id stage instruction
    input  logic brEq,                        // compare result for the ex instruction
    input  logic brLt,
    input  logic [`REG_ADDR_W-1:0] memRd,
    input  logic [`REG_ADDR_W-1:0] wbRd,
    input  logic predictedTaken,              // fetch prediction for the mem instruction
    output logic jumpEarly,
    output logic branchEarly,
    output ctrlPkg::immSelE immSel,
    output logic idMemRead,
    output logic branchSigned,
    output logic aluASel,
    output logic aluBSel,
    output ctrlPkg::aluOpE aluSel,
    output ctrlPkg::fwdSelE forwardA,
    output ctrlPkg::fwdSelE forwardB,
    output ctrlPkg::fwdSelE forwardDmem,
    output ctrlPkg::fwdSelE forwardBranchA,
    output ctrlPkg::fwdSelE forwardBranchB,
    output logic dmemWrite,
    output logic [`FUNCT3_W-1:0] memFunct3,
    output logic regWEn,
    output ctrlPkg::wbSelE regWbSel,
    output logic pcSel,
    output logic branchResolved,
    output logic actualTaken,
    output logic mispredict
);

    logic regWEnId;
    ctrlPkg::wbSelE wbSelId;

    exStageIf  exBus ();
    memStageIf memBus ();

    idDecoder u_idDecoder (
        .instruct(instruct), .jumpEarly(jumpEarly), .branchEarly(branchEarly),
        .immSel(immSel), .idMemRead(idMemRead), .regWEnId(regWEnId), .wbSelId(wbSelId)
    );

    ctrlPipeline u_ctrlPipeline (
        .clk(clk), .rst(rst), .instruct(instruct), .regWEnId(regWEnId), .wbSelId(wbSelId),
        .brEq(brEq), .brLt(brLt), .exBus(exBus.source), .memBus(memBus.source),
        .dmemWrite(dmemWrite), .memFunct3(memFunct3), .regWEn(regWEn), .regWbSel(regWbSel)
    );

    exControl u_exControl (
        .exBus(exBus.sink), .branchSigned(branchSigned), .aluASel(aluASel),
        .aluBSel(aluBSel), .aluSel(aluSel)
    );

    forwardUnit u_forwardUnit (
        .memRd(memRd), .wbRd(wbRd), .exBus(exBus.sink), .forwardA(forwardA),
        .forwardB(forwardB), .forwardDmem(forwardDmem), .forwardBranchA(forwardBranchA),
        .forwardBranchB(forwardBranchB)
    );

    branchResolver u_branchResolver (
        .predictedTaken(predictedTaken), .memBus(memBus.sink), .pcSel(pcSel),
        .branchResolved(branchResolved), .actualTaken(actualTaken), .mispredict(mispredict)
    );

endmodule

//--- verification/ctrlTopTb.sv
`timescale 1ns/1ps
`include "ctrlConsts_consts.svh"

module ctrlTopTb;

    localparam int MAX_VEC = 128;
    localparam int N_IN    = 5;   // brEq brLt memRd wbRd predictedTaken
    localparam int N_EXP   = 21;  // every top level output

    logic clk;
    logic rst;
    logic [`XLEN-1:0] instruct;
    logic brEq;
    logic brLt;
    logic [`REG_ADDR_W-1:0] memRd;
    logic [`REG_ADDR_W-1:0] wbRd;
    logic predictedTaken;

    logic jumpEarly, branchEarly, idMemRead;
    ctrlPkg::immSelE immSel;
    logic branchSigned, aluASel, aluBSel;
    ctrlPkg::aluOpE aluSel;
    ctrlPkg::fwdSelE forwardA, forwardB, forwardDmem, forwardBranchA, forwardBranchB;
    logic dmemWrite;
    logic [2:0] memFunct3;
    logic regWEn;
    ctrlPkg::wbSelE regWbSel;
    logic pcSel, branchResolved, actualTaken, mispredict;

    // vector table with one row per cycle
    string vecName [0:MAX_VEC-1];
    logic [`XLEN-1:0] vecInst [0:MAX_VEC-1];
    logic [31:0] vecIn  [0:MAX_VEC-1][0:N_IN-1];
    logic [31:0] vecExp [0:MAX_VEC-1][0:N_EXP-1];
    int numVec = 0;

    int errCount = 0;
    int testCount = 0;
    int badTests = 0;
    int cycleCount = 0;
    int cycleLimit = 0;  // 0 until the vectors are loaded
    logic testBad = 1'b0;
    int i;

    ctrlTop u_ctrlTop (.*);

    always #20 clk = ~clk;  // 40 ns period

    always @(posedge clk) cycleCount <= cycleCount + 1;

    ////////////////////
    // helpers
    ////////////////////
    task automatic loadVectors();
        int fd, code, k, ch;
        string tok;
        fd = $fopen("verification/ctrl_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file verification/ctrl_testdata.txt");
            errCount++;
        end else begin
            while (!$feof(fd) && numVec < MAX_VEC) begin
                code = $fscanf(fd, "%s", tok);
                if (code != 1)
                    break;  // end of file
                if (tok[0] == "#") begin
                    ch = $fgetc(fd);
                    while (ch != "\n" && ch != -1)
                        ch = $fgetc(fd);  // rest of the comment line
                end else begin
                    vecName[numVec] = tok;
                    code = $fscanf(fd, "%h", vecInst[numVec]);
                    for (k = 0; k < N_IN; k++)
                        code += $fscanf(fd, "%d", vecIn[numVec][k]);
                    for (k = 0; k < N_EXP; k++)
                        code += $fscanf(fd, "%d", vecExp[numVec][k]);
                    if (code != 1 + N_IN + N_EXP) begin
                        $display("vector line %0d (%s) has missing columns", numVec, tok);
                        errCount++;
                    end
                    numVec++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic applyVector(input int idx);
        instruct       = vecInst[idx];
        brEq           = vecIn[idx][0][0];
        brLt           = vecIn[idx][1][0];
        memRd          = vecIn[idx][2][`REG_ADDR_W-1:0];
        wbRd           = vecIn[idx][3][`REG_ADDR_W-1:0];
        predictedTaken = vecIn[idx][4][0];  // applies to the mem instruction
    endtask

    task automatic checkField(input int idx, input string field,
                              input logic [31:0] expVal, input logic [31:0] actVal);
        if (actVal !== expVal) begin
            $display("mismatch %s (vector %0d) %s expected %0d actual %0d",
                     vecName[idx], idx, field, expVal, actVal);
            errCount++;
            testBad = 1'b1;
        end
    endtask

    // id is this row, ex this row, mem the row before, wb two rows before
    task automatic checkVector(input int idx);
        checkField(idx, "jumpEarly", vecExp[idx][0], jumpEarly);
        checkField(idx, "branchEarly", vecExp[idx][1], branchEarly);
        checkField(idx, "immSel", vecExp[idx][2], immSel);
        checkField(idx, "idMemRead", vecExp[idx][3], idMemRead);
        checkField(idx, "branchSigned", vecExp[idx][4], branchSigned);
        checkField(idx, "aluASel", vecExp[idx][5], aluASel);
        checkField(idx, "aluBSel", vecExp[idx][6], aluBSel);
        checkField(idx, "aluSel", vecExp[idx][7], aluSel);
        checkField(idx, "forwardA", vecExp[idx][8], forwardA);
        checkField(idx, "forwardB", vecExp[idx][9], forwardB);
        checkField(idx, "forwardDmem", vecExp[idx][10], forwardDmem);
        checkField(idx, "forwardBranchA", vecExp[idx][11], forwardBranchA);
        checkField(idx, "forwardBranchB", vecExp[idx][12], forwardBranchB);
        checkField(idx, "dmemWrite", vecExp[idx][13], dmemWrite);
        checkField(idx, "memFunct3", vecExp[idx][14], memFunct3);
        checkField(idx, "pcSel", vecExp[idx][15], pcSel);
        checkField(idx, "branchResolved", vecExp[idx][16], branchResolved);
        checkField(idx, "actualTaken", vecExp[idx][17], actualTaken);
        checkField(idx, "mispredict", vecExp[idx][18], mispredict);
        checkField(idx, "regWEn", vecExp[idx][19], regWEn);
        checkField(idx, "regWbSel", vecExp[idx][20], regWbSel);
    endtask

    ////////////////////
    // main sequence
    ////////////////////
    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        instruct       = `INST_NOP;
        brEq           = 1'b0;
        brLt           = 1'b0;
        memRd          = '0;
        wbRd           = '0;
        predictedTaken = 1'b0;
        loadVectors();
        if (numVec == 0) begin
            $display("no test vectors were loaded");
            errCount++;
        end
        cycleLimit = 2 * numVec + 20;
        repeat (2) @(posedge clk);  // two reset cycles
        @(negedge clk);
        rst = 1'b0;
        for (i = 0; i < numVec; i++) begin
            applyVector(i);
            @(negedge clk);  // outputs settled since the rising edge
            checkVector(i);
            if (i == numVec - 1 || vecName[i + 1] != vecName[i]) begin
                testCount++;
                if (testBad)
                    badTests++;
                $display("test %-12s %s", vecName[i], testBad ? "FAIL" : "ok");
                testBad = 1'b0;
            end
        end
        $display("%0d tests, %0d failing, %0d mismatches over %0d vectors",
                 testCount, badTests, errCount, numVec);
        if (errCount == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    // watchdog
    initial begin
        wait (cycleLimit > 0 && cycleCount >= cycleLimit);
        $display("timeout: the run did not finish within %0d clock cycles", cycleLimit);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- sim.f
+incdir+src
src/ctrlPkg.sv
src/ctrlIf.sv
src/idDecoder.sv
src/ctrlPipeline.sv
src/exControl.sv
src/forwardUnit.sv
src/branchResolver.sv
src/ctrlTop.sv
verification/ctrlTopTb.sv

//--- verification/ctrl_testdata.txt
# name instruct brEq brLt memRd wbRd predictedTaken | then expected: jumpEarly branchEarly immSel idMemRead
# branchSigned aluASel aluBSel aluSel fwdA fwdB fwdDmem fwdBrA fwdBrB dmemWrite memFunct3 pcSel branchResolved actualTaken mispredict regWEn regWbSel
reset       00000013 0 0 0 0 0  0 0 0 0  0 0 1 0   0 0 0 0 0  0 0 0 0 0 0  0 0
reset       00000013 0 0 0 0 0  0 0 0 0  0 0 1 0   0 0 0 0 0  0 0 0 0 0 0  0 0
decode_alu  002081B3 0 0 0 0 0  0 0 0 0  0 0 0 0   0 0 0 0 0  0 0 0 0 0 0  1 1
decode_alu  40118233 0 0 0 0 0  0 0 0 0  0 0 0 1   0 0 0 0 0  0 0 0 0 0 0  1 1
decode_alu  402252B3 0 0 0 0 0  0 0 0 0  0 0 0 7   0 0 0 0 0  0 0 0 0 0 0  1 1
decode_alu  0050A313 0 0 0 0 0  0 0 0 0  0 0 1 9   0 0 0 0 0  0 5 0 0 0 0  1 1
decode_alu  4030D393 0 0 0 0 0  0 0 1 0  0 0 1 7   0 0 0 0 0  0 2 0 0 0 0  1 1
decode_alu  12345437 0 0 0 0 0  0 0 4 0  1 0 1 11  0 0 0 0 0  0 5 0 0 0 0  1 1
decode_alu  00001497 0 0 0 0 0  0 0 4 0  0 1 1 0   0 0 0 0 0  0 5 0 0 0 0  1 1
decode_mem  0000A503 0 0 0 0 0  0 0 0 1  0 0 1 0   0 0 0 0 0  0 1 0 0 0 0  1 1
decode_mem  0020A223 0 0 0 0 0  0 0 2 1  0 0 1 0   0 0 0 0 0  0 2 0 0 0 0  1 1
decode_mem  00008067 0 0 0 0 0  0 0 0 0  0 0 1 0   0 0 0 0 0  1 2 0 0 0 0  1 0
forwarding  002081B3 0 0 1 2 0  0 0 0 0  0 0 0 0   2 0 0 0 0  0 0 1 0 0 0  0 0
forwarding  002081B3 0 0 1 1 0  0 0 0 0  0 0 0 0   2 0 0 0 0  0 0 0 0 0 0  1 3
forwarding  002081B3 0 0 1 2 0  0 0 0 0  0 0 0 0   2 1 0 0 0  0 0 0 0 0 0  1 1
forwarding  00000013 0 0 0 0 0  0 0 0 0  0 0 1 0   0 0 0 0 0  0 0 0 0 0 0  1 1
forwarding  0020A223 0 0 2 1 0  0 0 2 1  0 0 1 0   1 0 2 0 0  0 0 0 0 0 0  1 1
forwarding  00208463 0 0 1 2 0  0 1 3 1  0 1 1 0   0 0 0 0 1  1 2 0 0 0 0  1 1
branch_beq  00208463 0 0 0 0 0  0 1 3 1  0 1 1 0   0 0 0 0 0  0 0 0 1 0 0  0 0
branch_beq  00208463 1 0 0 0 0  0 1 3 1  0 1 1 0   0 0 0 0 0  0 0 1 1 1 0  0 0
branch_beq  00208463 0 0 0 0 1  0 1 3 1  0 1 1 0   0 0 0 0 0  0 0 1 1 0 1  0 0
branch_beq  00209463 1 0 0 0 1  0 1 3 1  0 1 1 0   0 0 0 0 0  0 0 0 1 1 0  0 0
branch_bne  00209463 0 0 0 0 0  0 1 3 1  0 1 1 0   0 0 0 0 0  0 1 1 1 1 0  0 0
branch_bne  00209463 1 0 0 0 0  0 1 3 1  0 1 1 0   0 0 0 0 0  0 1 0 1 0 0  0 0
branch_bne  00209463 0 0 0 0 1  0 1 3 1  0 1 1 0   0 0 0 0 0  0 1 0 1 1 0  0 0
branch_bne  0020C463 1 0 0 0 1  0 1 3 1  0 1 1 0   0 0 0 0 0  0 1 1 1 0 1  0 0
branch_blt  0020C463 0 0 0 0 0  0 1 3 1  0 1 1 0   0 0 0 0 0  0 4 0 1 0 0  0 0
branch_blt  0020C463 0 1 0 0 0  0 1 3 1  0 1 1 0   0 0 0 0 0  0 4 1 1 1 0  0 0
branch_blt  0020C463 0 0 0 0 1  0 1 3 1  0 1 1 0   0 0 0 0 0  0 4 1 1 0 1  0 0
branch_blt  0020F463 0 1 0 0 1  0 1 3 1  1 1 1 0   0 0 0 0 0  0 4 0 1 1 0  0 0
branch_bgeu 0020F463 0 0 0 0 0  0 1 3 1  1 1 1 0   0 0 0 0 0  0 7 1 1 1 0  0 0
branch_bgeu 0020F463 0 1 0 0 0  0 1 3 1  1 1 1 0   0 0 0 0 0  0 7 0 1 0 0  0 0
branch_bgeu 0020F463 0 0 0 0 1  0 1 3 1  1 1 1 0   0 0 0 0 0  0 7 0 1 1 0  0 0
branch_bgeu 00000013 0 1 0 0 1  0 0 0 0  0 0 1 0   0 0 0 0 0  0 7 1 1 0 1  0 0
jump_store  010000EF 0 0 0 0 0  1 0 5 0  0 1 1 0   0 0 0 0 0  0 0 0 0 0 0  0 0
jump_store  010000EF 0 0 0 0 0  1 0 5 0  0 1 1 0   0 0 0 0 0  0 0 1 0 0 0  1 1
jump_store  00329023 0 0 0 0 1  0 0 2 1  0 0 1 0   0 0 0 0 0  0 0 0 0 0 0  1 3
jump_store  0020E463 0 0 0 0 0  0 1 3 1  1 1 1 0   0 0 0 0 0  1 1 0 0 0 0  1 3
writeback   0000A503 0 1 0 0 1  0 0 0 1  0 0 1 0   0 0 0 0 0  0 6 0 1 1 0  0 0
writeback   00000013 0 0 0 0 0  0 0 0 0  0 0 1 0   0 0 0 0 0  0 2 0 0 0 0  0 0
writeback   00000013 0 0 0 0 0  0 0 0 0  0 0 1 0   0 0 0 0 0  0 0 0 0 0 0  1 0
writeback   00000013 0 0 0 0 0  0 0 0 0  0 0 1 0   0 0 0 0 0  0 0 0 0 0 0  1 1
